// File: design/axi_burst_engine.sv
`timescale 1ns/100ps
`default_nettype none

module axi_burst_engine import dcache_axi_pkg::*; #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                     clock,
    input  wire                     reset,
    // head entry of the request queue
    input  wire                     ent_valid_i,
    input  wire                     ent_write_i,
    input  wire  [ADDR_WIDTH-1:0]   ent_addr_i,
    input  wire  line_u             ent_wdata_i,
    output logic                    ent_pop_o,
    // read address channel
    input  wire                     axi_ar_ready_i,
    output logic                    axi_ar_valid_o,
    output logic [ADDR_WIDTH-1:0]   axi_ar_addr_o,
    output logic [7:0]              axi_ar_len_o,
    output logic [2:0]              axi_ar_size_o,
    output logic [1:0]              axi_ar_burst_o,
    // read data channel
    output logic                    axi_r_ready_o,
    input  wire                     axi_r_valid_i,
    input  wire  [BEAT_WIDTH-1:0]   axi_r_data_i,
    input  wire  axi_resp_e         axi_r_resp_i,
    input  wire                     axi_r_last_i,
    // write address channel
    input  wire                     axi_aw_ready_i,
    output logic                    axi_aw_valid_o,
    output logic [ADDR_WIDTH-1:0]   axi_aw_addr_o,
    output logic [7:0]              axi_aw_len_o,
    output logic [2:0]              axi_aw_size_o,
    output logic [1:0]              axi_aw_burst_o,
    // write data channel
    input  wire                     axi_w_ready_i,
    output logic                    axi_w_valid_o,
    output logic [BEAT_WIDTH-1:0]   axi_w_data_o,
    output logic [BEAT_WIDTH/8-1:0] axi_w_strb_o,
    output logic                    axi_w_last_o,
    // write response channel
    output logic                    axi_b_ready_o,
    input  wire                     axi_b_valid_i,
    input  wire  axi_resp_e         axi_b_resp_i,
    // towards the assembler
    output logic                    beat_valid_o,
    output logic [BEAT_WIDTH-1:0]   beat_data_o,
    output axi_resp_e               beat_resp_o,
    output logic                    beat_last_o,
    output logic                    wr_done_o,
    output axi_resp_e               wr_resp_o
);

    localparam int OFS_BITS = $clog2(LINE_WIDTH / 8);
    localparam int CNT_W    = $clog2(LINE_BEATS);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_ADDR  = 3'd1;   // AR or AW pending
    localparam logic [2:0] S_RDATA = 3'd2;
    localparam logic [2:0] S_WDATA = 3'd3;
    localparam logic [2:0] S_WRESP = 3'd4;

    logic [2:0]            state;
    logic [2:0]            state_nxt;
    logic                  wr_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    line_u                 line_q;
    logic [CNT_W-1:0]      wcnt;
    logic [ADDR_WIDTH-1:0] line_addr;
    logic                  w_fire;
    logic                  last_beat;

    // take the head entry whenever the engine is free
    assign ent_pop_o = (state == S_IDLE) && ent_valid_i;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (ent_valid_i) begin
                    state_nxt = S_ADDR;
                end
            end
            S_ADDR: begin
                if (wr_q && axi_aw_ready_i) begin
                    state_nxt = S_WDATA;
                end else if (!wr_q && axi_ar_ready_i) begin
                    state_nxt = S_RDATA;
                end
            end
            S_RDATA: begin
                if (axi_r_valid_i && axi_r_last_i) begin
                    state_nxt = S_IDLE;
                end
            end
            S_WDATA: begin
                if (w_fire && last_beat) begin
                    state_nxt = S_WRESP;
                end
            end
            S_WRESP: begin
                if (axi_b_valid_i) begin
                    state_nxt = S_IDLE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= S_IDLE;
            wr_q  <= 1'b0;
            wcnt  <= '0;
        end else begin
            state <= state_nxt;
            if (ent_pop_o) begin
                wr_q <= ent_write_i;
                wcnt <= '0;
            end else if (w_fire) begin
                wcnt <= wcnt + 1'b1;
            end
        end
    end

    // burst payload, held until the burst is done
    always_ff @(posedge clock) begin
        if (ent_pop_o) begin
            addr_q <= ent_addr_i;
            line_q <= ent_wdata_i;
        end
    end

    // force line alignment
    assign line_addr = {addr_q[ADDR_WIDTH-1:OFS_BITS], {OFS_BITS{1'b0}}};

    assign axi_ar_valid_o = (state == S_ADDR) && !wr_q;
    assign axi_ar_addr_o  = line_addr;
    assign axi_ar_len_o   = AXI_LEN_LINE;
    assign axi_ar_size_o  = AXI_SIZE_BEAT;
    assign axi_ar_burst_o = AXI_BURST_INCR;
    assign axi_r_ready_o  = (state == S_RDATA);

    assign axi_aw_valid_o = (state == S_ADDR) && wr_q;
    assign axi_aw_addr_o  = line_addr;
    assign axi_aw_len_o   = AXI_LEN_LINE;
    assign axi_aw_size_o  = AXI_SIZE_BEAT;
    assign axi_aw_burst_o = AXI_BURST_INCR;

    assign last_beat      = (wcnt == CNT_W'(LINE_BEATS - 1));
    assign w_fire         = axi_w_valid_o && axi_w_ready_i;
    assign axi_w_valid_o  = (state == S_WDATA);
    assign axi_w_data_o   = line_q.beat[wcnt];   // beat picked by write count
    assign axi_w_strb_o   = '1;                  // whole lines only
    assign axi_w_last_o   = last_beat;
    assign axi_b_ready_o  = (state == S_WRESP);

    // accepted R beats and the B handshake go to the assembler
    assign beat_valid_o = axi_r_valid_i && axi_r_ready_o;
    assign beat_data_o  = axi_r_data_i;
    assign beat_resp_o  = axi_r_resp_i;
    assign beat_last_o  = axi_r_last_i;
    assign wr_done_o    = axi_b_valid_i && axi_b_ready_o;
    assign wr_resp_o    = axi_b_resp_i;

endmodule

`default_nettype wire

// File: design/dcache_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_axi_bridge import dcache_axi_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int REQ_DEPTH  = 4
) (
    input  wire                     clock,
    input  wire                     reset,
    // cache controller side
    input  wire                     req_valid_i,
    input  wire                     req_write_i,
    input  wire  [ADDR_WIDTH-1:0]   req_addr_i,
    input  wire  line_u             req_wdata_i,
    output logic                    req_credit_o,
    output logic                    rsp_valid_o,
    output logic                    rsp_write_o,
    output line_u                   rsp_rdata_o,
    output logic                    rsp_error_o,
    // AXI4 master
    input  wire                     axi_ar_ready_i,
    output logic                    axi_ar_valid_o,
    output logic [ADDR_WIDTH-1:0]   axi_ar_addr_o,
    output logic [7:0]              axi_ar_len_o,
    output logic [2:0]              axi_ar_size_o,
    output logic [1:0]              axi_ar_burst_o,
    output logic                    axi_r_ready_o,
    input  wire                     axi_r_valid_i,
    input  wire  [BEAT_WIDTH-1:0]   axi_r_data_i,
    input  wire  axi_resp_e         axi_r_resp_i,
    input  wire                     axi_r_last_i,
    input  wire                     axi_aw_ready_i,
    output logic                    axi_aw_valid_o,
    output logic [ADDR_WIDTH-1:0]   axi_aw_addr_o,
    output logic [7:0]              axi_aw_len_o,
    output logic [2:0]              axi_aw_size_o,
    output logic [1:0]              axi_aw_burst_o,
    input  wire                     axi_w_ready_i,
    output logic                    axi_w_valid_o,
    output logic [BEAT_WIDTH-1:0]   axi_w_data_o,
    output logic [BEAT_WIDTH/8-1:0] axi_w_strb_o,
    output logic                    axi_w_last_o,
    output logic                    axi_b_ready_o,
    input  wire                     axi_b_valid_i,
    input  wire  axi_resp_e         axi_b_resp_i
);

    // queue head to engine
    logic                  ent_valid;
    logic                  ent_write;
    logic [ADDR_WIDTH-1:0] ent_addr;
    line_u                 ent_wdata;
    logic                  ent_pop;

    // engine to assembler
    logic                  beat_valid;
    logic [BEAT_WIDTH-1:0] beat_data;
    axi_resp_e             beat_resp;
    logic                  beat_last;
    logic                  wr_done;
    axi_resp_e             wr_resp;

    line_req_queue #(.ADDR_WIDTH(ADDR_WIDTH), .REQ_DEPTH(REQ_DEPTH)) u_queue (
        .ent_pop_i   (ent_pop),
        .ent_valid_o (ent_valid),
        .ent_write_o (ent_write),
        .ent_addr_o  (ent_addr),
        .ent_wdata_o (ent_wdata),
        .*
    );

    axi_burst_engine #(.ADDR_WIDTH(ADDR_WIDTH)) u_engine (
        .ent_valid_i  (ent_valid),
        .ent_write_i  (ent_write),
        .ent_addr_i   (ent_addr),
        .ent_wdata_i  (ent_wdata),
        .ent_pop_o    (ent_pop),
        .beat_valid_o (beat_valid),
        .beat_data_o  (beat_data),
        .beat_resp_o  (beat_resp),
        .beat_last_o  (beat_last),
        .wr_done_o    (wr_done),
        .wr_resp_o    (wr_resp),
        .*            // AXI ports share the top level names
    );

    line_refill_assembler u_assembler (
        .beat_valid_i (beat_valid),
        .beat_data_i  (beat_data),
        .beat_resp_i  (beat_resp),
        .beat_last_i  (beat_last),
        .wr_done_i    (wr_done),
        .wr_resp_i    (wr_resp),
        .*
    );

endmodule

`default_nettype wire

// File: design/dcache_axi_pkg.sv
`default_nettype none

package dcache_axi_pkg;

    // one AXI data beat
    localparam int BEAT_WIDTH = 64;

    // beats per cache line, AXI len is one less
    localparam int LINE_BEATS = 4;
    localparam int LINE_WIDTH = BEAT_WIDTH * LINE_BEATS;

    // burst encodings shared by the engine and the memory model
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_BEAT  = 3'($clog2(BEAT_WIDTH / 8));
    localparam logic [7:0] AXI_LEN_LINE   = 8'(LINE_BEATS - 1);

    // a cache line, seen as one flat word or as beats (beat 0 in the low bits)
    typedef union packed {
        logic [LINE_WIDTH-1:0]                 word;
        logic [LINE_BEATS-1:0][BEAT_WIDTH-1:0] beat;
    } line_u;

    // AXI response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

`default_nettype wire

// File: design/line_refill_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module line_refill_assembler import dcache_axi_pkg::*; (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   beat_valid_i,
    input  wire  [BEAT_WIDTH-1:0] beat_data_i,
    input  wire  axi_resp_e       beat_resp_i,
    input  wire                   beat_last_i,
    input  wire                   wr_done_i,
    input  wire  axi_resp_e       wr_resp_i,
    output logic                  rsp_valid_o,
    output logic                  rsp_write_o,
    output line_u                 rsp_rdata_o,
    output logic                  rsp_error_o
);

    localparam int IDX_W = $clog2(LINE_BEATS);

    logic [IDX_W-1:0] beat_idx;
    logic             err_q;      // sticky over the beats of one burst
    line_u            line_q;
    logic             beat_bad;
    logic             wr_bad;

    assign beat_bad = (beat_resp_i == SLVERR) || (beat_resp_i == DECERR);
    assign wr_bad   = (wr_resp_i == SLVERR) || (wr_resp_i == DECERR);

    // last beat lands in the same edge that raises rsp_valid_o
    always_ff @(posedge clock) begin
        if (beat_valid_i) begin
            line_q.beat[beat_idx] <= beat_data_i;
        end
    end

    assign rsp_rdata_o = line_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            beat_idx    <= '0;
            err_q       <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_write_o <= 1'b0;
            rsp_error_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;   // single cycle pulse
            if (beat_valid_i) begin
                if (beat_last_i) begin
                    beat_idx    <= '0;
                    err_q       <= 1'b0;
                    rsp_valid_o <= 1'b1;
                    rsp_write_o <= 1'b0;
                    rsp_error_o <= err_q || beat_bad;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                    err_q    <= err_q || beat_bad;
                end
            end else if (wr_done_i) begin
                rsp_valid_o <= 1'b1;
                rsp_write_o <= 1'b1;
                rsp_error_o <= wr_bad;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/line_req_queue.sv
`timescale 1ns/100ps
`default_nettype none

module line_req_queue import dcache_axi_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int REQ_DEPTH  = 4
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   req_valid_i,
    input  wire                   req_write_i,
    input  wire  [ADDR_WIDTH-1:0] req_addr_i,
    input  wire  line_u           req_wdata_i,
    input  wire                   ent_pop_i,
    output logic                  ent_valid_o,
    output logic                  ent_write_o,
    output logic [ADDR_WIDTH-1:0] ent_addr_o,
    output line_u                 ent_wdata_o,
    output logic                  req_credit_o
);

    localparam int PTR_W = $clog2(REQ_DEPTH);

    // entry storage, one slot per credit
    logic                  write_mem [REQ_DEPTH];
    logic [ADDR_WIDTH-1:0] addr_mem  [REQ_DEPTH];
    line_u                 wdata_mem [REQ_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // one extra bit so a full queue is visible
    logic             pop;

    // controller never pushes without a credit, so no full check here
    always_ff @(posedge clock) begin
        if (req_valid_i) begin
            write_mem[wr_ptr] <= req_write_i;
            addr_mem[wr_ptr]  <= req_addr_i;
            wdata_mem[wr_ptr] <= req_wdata_i;
        end
    end

    assign pop = ent_pop_i && ent_valid_o;   // ignore a stray pop on empty

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, req_valid_i} - {{PTR_W{1'b0}}, pop};
            // credit goes back the cycle after the entry leaves
            req_credit_o <= pop;
        end
    end

    // head of queue
    assign ent_valid_o = (count != '0);
    assign ent_write_o = write_mem[rd_ptr];
    assign ent_addr_o  = addr_mem[rd_ptr];
    assign ent_wdata_o = wdata_mem[rd_ptr];

endmodule

`default_nettype wire

// File: flist.f
design/dcache_axi_pkg.sv
design/line_req_queue.sv
design/axi_burst_engine.sv
design/line_refill_assembler.sv
design/dcache_axi_bridge.sv
sim/axi_mem_model.sv
sim/tb_dcache_axi_bridge.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_dcache_axi_bridge -f flist.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulation exited with a nonzero status" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

// File: sim/axi_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model import dcache_axi_pkg::*; #(
    parameter int                    ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] ERR_BASE   = '1
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     stall_en_i,   // random gaps on ready and valid
    input  wire                     ar_valid_i,
    input  wire  [ADDR_WIDTH-1:0]   ar_addr_i,
    input  wire  [7:0]              ar_len_i,
    input  wire  [2:0]              ar_size_i,
    input  wire  [1:0]              ar_burst_i,
    output logic                    ar_ready_o,
    output logic                    r_valid_o,
    output logic [BEAT_WIDTH-1:0]   r_data_o,
    output axi_resp_e               r_resp_o,
    output logic                    r_last_o,
    input  wire                     r_ready_i,
    input  wire                     aw_valid_i,
    input  wire  [ADDR_WIDTH-1:0]   aw_addr_i,
    input  wire  [7:0]              aw_len_i,
    input  wire  [2:0]              aw_size_i,
    input  wire  [1:0]              aw_burst_i,
    output logic                    aw_ready_o,
    input  wire                     w_valid_i,
    input  wire  [BEAT_WIDTH-1:0]   w_data_i,
    input  wire  [BEAT_WIDTH/8-1:0] w_strb_i,
    input  wire                     w_last_i,
    output logic                    w_ready_o,
    output logic                    b_valid_o,
    output axi_resp_e               b_resp_o,
    input  wire                     b_ready_i,
    output logic                    proto_err_o
);

    localparam int BEAT_BYTES = BEAT_WIDTH / 8;

    logic [BEAT_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];   // beats by byte address
    logic                  rd_active;
    logic                  wr_active;
    logic                  b_pend;       // last W seen, B not yet accepted
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [1:0]            rd_cnt;
    logic [1:0]            wr_cnt;

    // slot is open unless a random stall hits
    function automatic logic slot_open();
        return !stall_en_i || ($urandom % 4 != 0);
    endfunction

    // four beats of eight bytes, INCR, line aligned
    function automatic logic burst_ok(input logic [7:0] len, input logic [2:0] size,
                                      input logic [1:0] burst,
                                      input logic [ADDR_WIDTH-1:0] addr);
        return (len == 8'd3) && (size == 3'd3) && (burst == 2'b01) && (addr[4:0] == 5'd0);
    endfunction

    function automatic logic [BEAT_WIDTH-1:0] read_beat(input logic [ADDR_WIDTH-1:0] a);
        if (a >= ERR_BASE) begin
            return '0;
        end
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~32'(a), 32'(a)};   // unwritten memory reads back its own address
    endfunction

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o  <= 1'b0;
            aw_ready_o  <= 1'b0;
            w_ready_o   <= 1'b0;
            r_valid_o   <= 1'b0;
            r_data_o    <= '0;
            r_resp_o    <= OKAY;
            r_last_o    <= 1'b0;
            b_valid_o   <= 1'b0;
            b_resp_o    <= OKAY;
            rd_active   <= 1'b0;
            wr_active   <= 1'b0;
            b_pend      <= 1'b0;
            rd_addr     <= '0;
            wr_addr     <= '0;
            rd_cnt      <= '0;
            wr_cnt      <= '0;
            proto_err_o <= 1'b0;
        end else begin
            if (ar_valid_i && ar_ready_o) begin
                if (!burst_ok(ar_len_i, ar_size_i, ar_burst_i, ar_addr_i)) begin
                    $display("memory model: read burst at %h is not a line burst", ar_addr_i);
                    proto_err_o <= 1'b1;
                end
                rd_active  <= 1'b1;
                rd_addr    <= ar_addr_i;
                rd_cnt     <= '0;
                ar_ready_o <= 1'b0;
            end else begin
                ar_ready_o <= !rd_active && slot_open();
            end

            // R beats, held until rready
            if (rd_active) begin
                if (r_valid_o && r_ready_i) begin
                    r_valid_o <= 1'b0;
                    rd_cnt    <= rd_cnt + 1'b1;
                    if (r_last_o) begin
                        rd_active <= 1'b0;
                    end
                end else if (!r_valid_o && slot_open()) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= read_beat(rd_addr + ADDR_WIDTH'(rd_cnt * BEAT_BYTES));
                    r_resp_o  <= (rd_addr >= ERR_BASE) ? SLVERR : OKAY;
                    r_last_o  <= (rd_cnt == 2'd3);
                end
            end

            if (aw_valid_i && aw_ready_o) begin
                if (!burst_ok(aw_len_i, aw_size_i, aw_burst_i, aw_addr_i)) begin
                    $display("memory model: write burst at %h is not a line burst", aw_addr_i);
                    proto_err_o <= 1'b1;
                end
                wr_active  <= 1'b1;
                wr_addr    <= aw_addr_i;
                wr_cnt     <= '0;
                aw_ready_o <= 1'b0;
            end else begin
                aw_ready_o <= !wr_active && !b_pend && slot_open();
            end

            if (w_valid_i && !wr_active) begin
                $display("memory model: write data arrived before its address");
                proto_err_o <= 1'b1;
            end
            if (w_valid_i && w_ready_o) begin
                if (w_strb_i != '1) begin
                    $display("memory model: write strobes are not all ones");
                    proto_err_o <= 1'b1;
                end
                if (w_last_i != (wr_cnt == 2'd3)) begin
                    $display("memory model: wlast is not on the fourth beat only");
                    proto_err_o <= 1'b1;
                end
                if (wr_addr < ERR_BASE) begin
                    mem[wr_addr + ADDR_WIDTH'(wr_cnt * BEAT_BYTES)] = w_data_i;
                end
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == 2'd3) begin   // beat count ends the burst, not wlast
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                    w_ready_o <= 1'b0;
                end else begin
                    w_ready_o <= slot_open();
                end
            end else begin
                w_ready_o <= wr_active && slot_open();
            end

            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                b_pend    <= 1'b0;
            end else if (b_pend && !b_valid_o && slot_open()) begin
                b_valid_o <= 1'b1;
                b_resp_o  <= (wr_addr >= ERR_BASE) ? SLVERR : OKAY;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_dcache_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_axi_bridge import dcache_axi_pkg::*; ();

    localparam int                    ADDR_WIDTH = 32;
    localparam int                    REQ_DEPTH  = 4;
    localparam logic [ADDR_WIDTH-1:0] ERR_BASE   = 32'h8000_0000;
    localparam int                    BP_LINES   = 6;
    localparam int                    NUM_REQS   = 2 + 2 * REQ_DEPTH + 2 * BP_LINES + 4;
    localparam int                    BURST_MAX  = 200;   // cycles per burst with stalls
    localparam int                    TIMEOUT_NS = (NUM_REQS * BURST_MAX + 50) * 10;

    logic                    clock;
    logic                    reset;
    logic                    stall_en;
    logic                    req_valid_i;
    logic                    req_write_i;
    logic [ADDR_WIDTH-1:0]   req_addr_i;
    line_u                   req_wdata_i;
    logic                    req_credit_o;
    logic                    rsp_valid_o;
    logic                    rsp_write_o;
    line_u                   rsp_rdata_o;
    logic                    rsp_error_o;
    logic                    axi_ar_ready_i;
    logic                    axi_ar_valid_o;
    logic [ADDR_WIDTH-1:0]   axi_ar_addr_o;
    logic [7:0]              axi_ar_len_o;
    logic [2:0]              axi_ar_size_o;
    logic [1:0]              axi_ar_burst_o;
    logic                    axi_r_ready_o;
    logic                    axi_r_valid_i;
    logic [BEAT_WIDTH-1:0]   axi_r_data_i;
    axi_resp_e               axi_r_resp_i;
    logic                    axi_r_last_i;
    logic                    axi_aw_ready_i;
    logic                    axi_aw_valid_o;
    logic [ADDR_WIDTH-1:0]   axi_aw_addr_o;
    logic [7:0]              axi_aw_len_o;
    logic [2:0]              axi_aw_size_o;
    logic [1:0]              axi_aw_burst_o;
    logic                    axi_w_ready_i;
    logic                    axi_w_valid_o;
    logic [BEAT_WIDTH-1:0]   axi_w_data_o;
    logic [BEAT_WIDTH/8-1:0] axi_w_strb_o;
    logic                    axi_w_last_o;
    logic                    axi_b_ready_o;
    logic                    axi_b_valid_i;
    axi_resp_e               axi_b_resp_i;
    logic                    proto_err;

    line_u ref_mem [logic [ADDR_WIDTH-1:0]];   // expected contents per line
    logic  exp_write_q [$];
    logic  exp_error_q [$];
    line_u exp_line_q  [$];
    logic  got_write_q [$];
    logic  got_error_q [$];
    line_u got_line_q  [$];
    int    credit_pulses;
    int    accepted;
    int    sent;
    int    failures;

    dcache_axi_bridge #(.ADDR_WIDTH(ADDR_WIDTH), .REQ_DEPTH(REQ_DEPTH)) u_dut (.*);

    axi_mem_model #(.ADDR_WIDTH(ADDR_WIDTH), .ERR_BASE(ERR_BASE)) u_mem (
        .clock       (clock),
        .reset       (reset),
        .stall_en_i  (stall_en),
        .ar_valid_i  (axi_ar_valid_o),
        .ar_addr_i   (axi_ar_addr_o),
        .ar_len_i    (axi_ar_len_o),
        .ar_size_i   (axi_ar_size_o),
        .ar_burst_i  (axi_ar_burst_o),
        .ar_ready_o  (axi_ar_ready_i),
        .r_valid_o   (axi_r_valid_i),
        .r_data_o    (axi_r_data_i),
        .r_resp_o    (axi_r_resp_i),
        .r_last_o    (axi_r_last_i),
        .r_ready_i   (axi_r_ready_o),
        .aw_valid_i  (axi_aw_valid_o),
        .aw_addr_i   (axi_aw_addr_o),
        .aw_len_i    (axi_aw_len_o),
        .aw_size_i   (axi_aw_size_o),
        .aw_burst_i  (axi_aw_burst_o),
        .aw_ready_o  (axi_aw_ready_i),
        .w_valid_i   (axi_w_valid_o),
        .w_data_i    (axi_w_data_o),
        .w_strb_i    (axi_w_strb_o),
        .w_last_i    (axi_w_last_o),
        .w_ready_o   (axi_w_ready_i),
        .b_valid_o   (axi_b_valid_i),
        .b_resp_o    (axi_b_resp_i),
        .b_ready_i   (axi_b_ready_o),
        .proto_err_o (proto_err)
    );

    always #5 clock = ~clock;

    task automatic abort_run();
        failures++;
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input string what, input line_u got, input line_u exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got %h", $time, what, got.word);
            $display("FAILED at %0d ns: %s exp %h", $time, what, exp.word);
            abort_run();
        end
    endtask

    task automatic check_resp(input string what, input logic got_write, input logic got_err,
                              input logic exp_write, input logic exp_err);
        if (got_write !== exp_write || got_err !== exp_err) begin
            $display("FAILED at %0d ns: %s write %b error %b, expected write %b error %b",
                     $time, what, got_write, got_err, exp_write, exp_err);
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // bookkeeping, sampled where DUT outputs are stable
    always @(posedge clock) begin
        if (req_credit_o) begin
            credit_pulses <= credit_pulses + 1;
            if (credit_pulses >= accepted) begin
                $display("a credit came back with no request waiting in the bridge");
                abort_run();
            end
        end
        if (req_valid_i) begin
            accepted <= accepted + 1;
        end
        if (rsp_valid_o) begin
            got_write_q.push_back(rsp_write_o);
            got_error_q.push_back(rsp_error_o);
            got_line_q.push_back(rsp_rdata_o);
        end
        if (proto_err) begin
            $display("the memory model saw an AXI burst format violation");
            abort_run();
        end
    end

    function automatic line_u random_line();
        line_u l;
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            l.word[i*32 +: 32] = $urandom();
        end
        return l;
    endfunction

    // called on a falling edge, waits for a credit first
    task automatic send_req(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                            input line_u data);
        logic  err;
        line_u exp;
        err = (addr >= ERR_BASE);
        exp = '0;
        while (sent - credit_pulses >= REQ_DEPTH) begin
            @(negedge clock);
        end
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = data;
        sent++;
        if (write && !err) begin
            ref_mem[addr] = data;
        end else if (!write && ref_mem.exists(addr)) begin
            exp = ref_mem[addr];
        end
        exp_write_q.push_back(write);
        exp_error_q.push_back(err);
        exp_line_q.push_back(exp);
        @(negedge clock);
        req_valid_i = 1'b0;
    endtask

    task automatic drain_and_check(input string what);
        logic  exp_write;
        logic  exp_err;
        line_u exp_line;
        logic  got_write;
        logic  got_err;
        line_u got_line;
        while (got_write_q.size() < exp_write_q.size()) begin
            @(negedge clock);
        end
        while (exp_write_q.size() > 0) begin
            exp_write = exp_write_q.pop_front();
            exp_err   = exp_error_q.pop_front();
            exp_line  = exp_line_q.pop_front();
            got_write = got_write_q.pop_front();
            got_err   = got_error_q.pop_front();
            got_line  = got_line_q.pop_front();
            check_resp(what, got_write, got_err, exp_write, exp_err);
            if (!exp_write && !exp_err) begin
                check_line(what, got_line, exp_line);
            end
        end
    endtask

    task automatic test_write_read_back();
        send_req(1'b1, 32'h0000_1240, random_line());
        drain_and_check("write before read back");
        send_req(1'b0, 32'h0000_1240, '0);
        drain_and_check("read back");
    endtask

    task automatic test_credits_order();
        int pulses0;
        pulses0 = credit_pulses;
        for (int i = 0; i < REQ_DEPTH; i++) begin
            send_req(1'b1, 32'h0000_4000 + 32'(i) * 32, random_line());
        end
        drain_and_check("back to back writes");
        check_count("credit pulses after writes", credit_pulses - pulses0, REQ_DEPTH);
        for (int i = 0; i < REQ_DEPTH; i++) begin
            send_req(1'b0, 32'h0000_4000 + 32'(i) * 32, '0);
        end
        drain_and_check("back to back reads in order");
        check_count("credit pulses after reads", credit_pulses - pulses0, 2 * REQ_DEPTH);
    endtask

    task automatic test_back_pressure();
        logic [ADDR_WIDTH-1:0] addrs [BP_LINES];
        stall_en = 1'b1;
        for (int i = 0; i < BP_LINES; i++) begin
            addrs[i] = $urandom() & 32'h7fff_ffe0;   // aligned, below the error region
            send_req(1'b1, addrs[i], random_line());
        end
        for (int i = 0; i < BP_LINES; i++) begin
            send_req(1'b0, addrs[i], '0);
        end
        drain_and_check("lines under AXI stalls");
        stall_en = 1'b0;
    endtask

    task automatic test_error_region();
        send_req(1'b0, ERR_BASE + 32'h40, '0);
        send_req(1'b1, ERR_BASE + 32'h80, random_line());
        send_req(1'b1, 32'h0000_2000, random_line());
        send_req(1'b0, 32'h0000_2000, '0);   // clean again after the errors
        drain_and_check("error region");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        void'($urandom(32'h13ef_f26a));
        clock         = 1'b0;
        reset         = 1'b0;
        stall_en      = 1'b0;
        req_valid_i   = 1'b0;
        req_write_i   = 1'b0;
        req_addr_i    = '0;
        req_wdata_i   = '0;
        credit_pulses = 0;
        accepted      = 0;
        sent          = 0;
        failures      = 0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        check_count("idle outputs in reset", int'({req_credit_o, rsp_valid_o, axi_ar_valid_o,
                    axi_aw_valid_o, axi_w_valid_o, axi_r_ready_o, axi_b_ready_o}), 0);
        reset = 1'b1;
        @(negedge clock);
        test_write_read_back();
        test_credits_order();
        test_back_pressure();
        test_error_region();
        repeat (10) @(negedge clock);
        check_count("extra responses", got_write_q.size(), 0);
        if (failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
